// File: Makefile
SIM      = verilator
TOP      = tb_uart_bridge
FILELIST = uart_bridge.f
FLAGS    = --binary --timing -j 0 --top-module $(TOP)
OBJ_DIR  = obj_dir

SRCS     = $(shell grep -v '^+' $(FILELIST))
HDRS     = design/uart_bridge_config.svh
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: design/uart_apb_regs.sv
`include "uart_bridge_config.svh"

module uart_apb_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`UART_APB_AW-1:0]   paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  input  logic                      busy,
  input  logic                      done,
  input  logic [7:0]                rx_byte,
  input  logic                      rx_parity_ok,
  input  logic                      resp_timeout_hit,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      start,
  output uart_frame_pkg::cmd_word_t cmd
);

  import uart_frame_pkg::*;
  import uart_bus_pkg::*;

  reg_addr_t addr;
  logic      wr_acc;
  logic      rd_acc;
  cmd_word_t cmd_q;
  status_t   status_q;
  logic [7:0] rdata_q;

  assign addr   = reg_addr_t'(paddr);
  assign wr_acc = psel && penable && pwrite;    // Access phase with no wait states
  assign rd_acc = psel && penable && !pwrite;

  assign pready  = 1'b1;
  assign start   = wr_acc && (addr == CMD) && !busy;
  assign pslverr = wr_acc && (addr == CMD) && busy;   // One command in flight
  assign cmd     = cmd_q;

  always_comb
  begin
    case (addr)
      CMD:     prdata = {16'h0, cmd_q};
      STATUS:  prdata = {28'h0, status_q};
      RDATA:   prdata = {24'h0, rdata_q};
      default: prdata = 32'h0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (start)
      cmd_q <= cmd_word_t'(pwdata[15:0]);
    if (done && !resp_timeout_hit && !cmd_q.fields.wr)
      rdata_q <= rx_byte;                              // Overwrites an unread byte
  end

  ////////////////////
  // Status flags
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      status_q <= '0;
    else
    begin
      status_q.busy <= start || (busy && !done);      // Falls with the result flags
      if (start)
        status_q.resp_timeout <= 1'b0;
      if (done && resp_timeout_hit)
        status_q.resp_timeout <= 1'b1;
      else if (done && !cmd_q.fields.wr)
      begin
        status_q.rx_valid   <= 1'b1;
        status_q.parity_err <= !rx_parity_ok;
      end
      else if (rd_acc && (addr == RDATA))
      begin
        status_q.rx_valid   <= 1'b0;
        status_q.parity_err <= 1'b0;
      end
    end
  end

endmodule

// File: design/uart_baud_timer.sv
`include "uart_bridge_config.svh"

module uart_baud_timer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        timer_load,
  input  uart_frame_pkg::timer_mode_t timer_mode,
  output logic                        bit_tick,
  output logic                        expire
);

  import uart_frame_pkg::*;

  localparam logic [15:0] BIT_LEN  = 16'(`UART_BIT_CYCLES);
  // FSM and tx shifter each add one cycle around the gap
  localparam logic [15:0] GAP_LEN  = 16'(`UART_GAP_CYCLES - 2);
  localparam logic [15:0] RESP_LEN = 16'(`UART_RESP_CYCLES);

  timer_mode_t mode_q;
  logic        active;
  logic [15:0] cnt;
  logic [15:0] load_len;

  always_comb
  begin
    case (timer_mode)
      TMR_GAP:  load_len = GAP_LEN;
      TMR_RESP: load_len = RESP_LEN;
      default:  load_len = BIT_LEN;
    endcase
  end

  assign bit_tick = active && (cnt == 16'd0) && (mode_q == TMR_BIT);
  assign expire   = active && (cnt == 16'd0) && (mode_q != TMR_BIT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mode_q <= TMR_BIT;
      active <= 1'b0;
      cnt    <= 16'd0;
    end
    else if (timer_load)
    begin
      mode_q <= timer_mode;
      active <= 1'b1;
      cnt    <= load_len - 16'd1;
    end
    else if (active)
    begin
      if (cnt != 16'd0)
        cnt <= cnt - 16'd1;
      else if (mode_q == TMR_BIT)
        cnt <= BIT_LEN - 16'd1;          // Free-running bit clock
      else
        active <= 1'b0;                  // One shot
    end
  end

endmodule

// File: design/uart_bridge.sv
`include "uart_bridge_config.svh"

module uart_bridge (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`UART_APB_AW-1:0] paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  logic                    rx,
  output logic                    tx
);

  import uart_frame_pkg::*;

  cmd_word_t   cmd;
  timer_mode_t timer_mode;
  logic        start;
  logic        busy;
  logic        done;
  logic        resp_timeout_hit;
  logic        timer_load;
  logic        bit_tick;
  logic        expire;
  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_done;
  logic        rx_en;
  logic        rx_started;
  logic        rx_done;
  logic [7:0]  rx_byte;
  logic        rx_parity_ok;

  uart_apb_regs i_regs (
    .clk              (clk),
    .rst_n            (rst_n),
    .paddr            (paddr),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .pwdata           (pwdata),
    .busy             (busy),
    .done             (done),
    .rx_byte          (rx_byte),
    .rx_parity_ok     (rx_parity_ok),
    .resp_timeout_hit (resp_timeout_hit),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .start            (start),
    .cmd              (cmd)
  );

  uart_seq_fsm i_seq (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .cmd              (cmd),
    .expire           (expire),
    .tx_done          (tx_done),
    .rx_started       (rx_started),
    .rx_done          (rx_done),
    .busy             (busy),
    .done             (done),
    .resp_timeout_hit (resp_timeout_hit),
    .timer_load       (timer_load),
    .timer_mode       (timer_mode),
    .tx_start         (tx_start),
    .tx_byte          (tx_byte),
    .rx_en            (rx_en)
  );

  uart_baud_timer i_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .timer_load (timer_load),
    .timer_mode (timer_mode),
    .bit_tick   (bit_tick),
    .expire     (expire)
  );

  uart_tx_shifter i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .bit_tick (bit_tick),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_sampler i_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .rx_en        (rx_en),
    .rx_started   (rx_started),
    .rx_done      (rx_done),
    .rx_byte      (rx_byte),
    .rx_parity_ok (rx_parity_ok)
  );

endmodule

// File: design/uart_bridge_config.svh
`ifndef UART_BRIDGE_CONFIG_SVH
`define UART_BRIDGE_CONFIG_SVH

// Clock cycles per UART bit, kept small for simulation (434 for 115200 at 50 MHz)
`define UART_BIT_CYCLES  16

// Idle cycles on tx between the stop bit of the hi frame and the start of the lo frame
// Must be at least 3
`define UART_GAP_CYCLES  8

// Cycles a read waits for the response start bit
`define UART_RESP_CYCLES 400

`define UART_APB_AW      4

`endif

// File: design/uart_bus_pkg.sv
`include "uart_bridge_config.svh"

package uart_bus_pkg;

  // Byte offsets of the APB registers
  typedef enum logic [`UART_APB_AW-1:0] {
    CMD    = 'h0,
    STATUS = 'h4,
    RDATA  = 'h8
  } reg_addr_t;

  typedef struct packed {
    logic busy;
    logic rx_valid;
    logic parity_err;
    logic resp_timeout;
  } status_t;

endpackage

// File: design/uart_frame_pkg.sv
package uart_frame_pkg;

  typedef struct packed {
    logic       wr;   // 1 = write, 0 = read
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_fields_t;

  typedef struct packed {
    logic [7:0] hi;   // Sent first
    logic [7:0] lo;
  } cmd_bytes_t;

  // Same 16 bits, seen as a command or as the two frames on the line
  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_t;

  typedef enum logic [2:0] {
    IDLE, SEND_HI, GAP, SEND_LO, WAIT_RESP, RECV
  } seq_state_t;

  typedef enum logic [1:0] {
    TMR_BIT  = 2'd0,
    TMR_GAP  = 2'd1,
    TMR_RESP = 2'd2
  } timer_mode_t;

endpackage

// File: design/uart_rx_sampler.sv
`include "uart_bridge_config.svh"

module uart_rx_sampler (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_en,
  output logic       rx_started,
  output logic       rx_done,
  output logic [7:0] rx_byte,
  output logic       rx_parity_ok
);

  localparam logic [15:0] BIT_LEN  = 16'(`UART_BIT_CYCLES);
  localparam logic [15:0] HALF_LEN = 16'(`UART_BIT_CYCLES / 2);

  logic        rx_meta;
  logic        rx_sync;
  logic        rx_prev;
  logic        active;
  logic [15:0] cnt;
  logic [3:0]  bit_idx;    // 0 start, 1..8 data, 9 parity, 10 stop
  logic        par_q;
  logic        sample;

  ////////////////////
  // Synchronizer and edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_started   = rx_en && !active && rx_prev && !rx_sync;
  assign sample       = active && (cnt == 16'd0);
  assign rx_done      = sample && (bit_idx == 4'd10);   // Middle of stop bit
  assign rx_parity_ok = ^{par_q, rx_byte};              // Odd count of ones

  ////////////////////
  // Mid-bit sampling
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      cnt     <= 16'd0;
      bit_idx <= 4'd0;
    end
    else if (rx_started)
    begin
      active  <= 1'b1;
      cnt     <= HALF_LEN - 16'd1;
      bit_idx <= 4'd0;
    end
    else if (sample)
    begin
      cnt     <= BIT_LEN - 16'd1;
      bit_idx <= bit_idx + 4'd1;
      if (bit_idx == 4'd10)
        active <= 1'b0;
    end
    else if (active)
      cnt <= cnt - 16'd1;
  end

  always_ff @(posedge clk)
  begin
    if (sample && (bit_idx >= 4'd1) && (bit_idx <= 4'd8))
      rx_byte <= {rx_sync, rx_byte[7:1]};     // LSB arrives first
    if (sample && (bit_idx == 4'd9))
      par_q <= rx_sync;
  end

endmodule

// File: design/uart_seq_fsm.sv
module uart_seq_fsm (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  uart_frame_pkg::cmd_word_t   cmd,
  input  logic                        expire,
  input  logic                        tx_done,
  input  logic                        rx_started,
  input  logic                        rx_done,
  output logic                        busy,
  output logic                        done,
  output logic                        resp_timeout_hit,
  output logic                        timer_load,
  output uart_frame_pkg::timer_mode_t timer_mode,
  output logic                        tx_start,
  output logic [7:0]                  tx_byte,
  output logic                        rx_en
);

  import uart_frame_pkg::*;

  seq_state_t state_q;

  assign busy    = (state_q != IDLE);
  assign tx_byte = (state_q == SEND_LO) ? cmd.bytes.lo : cmd.bytes.hi;

  // Start edge wins over a timeout in the same cycle
  assign resp_timeout_hit = (state_q == WAIT_RESP) && expire && !rx_started;

  assign done = ((state_q == SEND_LO) && tx_done && cmd.fields.wr) ||
                ((state_q == RECV) && rx_done) ||
                resp_timeout_hit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= IDLE;
      timer_load <= 1'b0;
      timer_mode <= TMR_BIT;
      tx_start   <= 1'b0;
      rx_en      <= 1'b0;
    end
    else
    begin
      timer_load <= 1'b0;
      tx_start   <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (start)
          begin
            state_q    <= SEND_HI;
            tx_start   <= 1'b1;
            timer_load <= 1'b1;
            timer_mode <= TMR_BIT;
          end
        end
        SEND_HI:
        begin
          if (tx_done)
          begin
            state_q    <= GAP;
            timer_load <= 1'b1;
            timer_mode <= TMR_GAP;
          end
        end
        GAP:
        begin
          if (expire)
          begin
            state_q    <= SEND_LO;
            tx_start   <= 1'b1;
            timer_load <= 1'b1;
            timer_mode <= TMR_BIT;
          end
        end
        SEND_LO:
        begin
          if (tx_done && cmd.fields.wr)
            state_q <= IDLE;
          else if (tx_done)
          begin
            state_q    <= WAIT_RESP;
            timer_load <= 1'b1;
            timer_mode <= TMR_RESP;
            rx_en      <= 1'b1;
          end
        end
        WAIT_RESP:
        begin
          if (rx_started)
            state_q <= RECV;               // Timer runs out unheeded
          else if (expire)
          begin
            state_q <= IDLE;
            rx_en   <= 1'b0;
          end
        end
        RECV:
        begin
          if (rx_done)
          begin
            state_q <= IDLE;
            rx_en   <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: design/uart_tx_shifter.sv
module uart_tx_shifter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  input  logic       bit_tick,
  output logic       tx,
  output logic       tx_done
);

  logic       active;
  logic [3:0] bit_cnt;     // 0 start, 1..8 data, 9 parity, 10 stop
  logic [9:0] shreg;

  // Last cycle of the stop bit
  assign tx_done = active && bit_tick && (bit_cnt == 4'd10);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      bit_cnt <= 4'd0;
      tx      <= 1'b1;       // Line idles high
    end
    else if (tx_start)
    begin
      active  <= 1'b1;
      bit_cnt <= 4'd0;
      tx      <= 1'b0;       // Start bit
    end
    else if (active && bit_tick)
    begin
      if (bit_cnt == 4'd10)
        active <= 1'b0;
      else
      begin
        bit_cnt <= bit_cnt + 4'd1;
        tx      <= shreg[0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_start)
      shreg <= {1'b1, ~^tx_byte, tx_byte};    // Stop, odd parity, data LSB first
    else if (active && bit_tick)
      shreg <= {1'b1, shreg[9:1]};
  end

endmodule

// File: tb/tb_uart_bridge.sv
`include "uart_bridge_config.svh"

module tb_uart_bridge;

  import uart_frame_pkg::*;
  import uart_bus_pkg::*;

  localparam int BIT = `UART_BIT_CYCLES;
  localparam int GAP = `UART_GAP_CYCLES;

  logic                    clk;
  logic                    rst_n;
  logic [`UART_APB_AW-1:0] paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    rx;
  logic                    tx;

  int          cyc = 0;
  int          cyc_limit = 0;
  int          last_acc;
  logic [7:0]  byte_q[$];      // Decoded tx frames
  int          start_q[$];     // Cycle of each tx start edge
  string       t_name[$];
  logic [15:0] t_cmd[$];
  int          t_rej[$];
  int          t_hasresp[$];
  logic [7:0]  t_resp[$];
  int          t_cor[$];
  logic [3:0]  t_stat[$];
  logic [7:0]  t_rdata[$];

  uart_bridge i_uart_bridge (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rx      (rx),
    .tx      (tx)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc_limit > 0 && cyc >= cyc_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cyc_limit);
      stop_on_error();
    end
  end

  ////////////////////
  // Failure handling
  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic fail_msg(input string msg);
    $display("%s", msg);
    stop_on_error();
  endtask

  task automatic check_cmd(input string name, input cmd_word_t exp, input cmd_word_t act);
    if (exp !== act)
    begin
      $display("[FAIL] %s cmd frames expected %h %h actual %h %h", name,
               exp.bytes.hi, exp.bytes.lo, act.bytes.hi, act.bytes.lo);
      stop_on_error();
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (exp !== act)
    begin
      $display("[FAIL] %s status expected %b actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      $display("[FAIL] %s rdata expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s expected %b actual %b", name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_cycles(input string name, input string what, input int exp,
                              input int act);
    if (exp != act)
    begin
      $display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
      stop_on_error();
    end
  endtask

  ////////////////////
  // APB driver entered and left 10 units after a rising edge
  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic apb_write(input reg_addr_t a, input logic [31:0] d, output logic err);
    paddr  = a;
    pwdata = d;
    pwrite = 1'b1;
    psel   = 1'b1;
    @(posedge clk);
    #10;
    penable  = 1'b1;
    last_acc = cyc;          // Access cycle
    #20;
    err = pslverr;
    if (pready !== 1'b1)
      fail_msg("pready was low during an APB write access");
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input reg_addr_t a, output logic [31:0] d);
    paddr  = a;
    pwrite = 1'b0;
    psel   = 1'b1;
    @(posedge clk);
    #10;
    penable = 1'b1;
    #20;
    d = prdata;
    if (pready !== 1'b1)
      fail_msg("pready was low during an APB read access");
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_idle(output status_t st);
    logic [31:0] d;
    do
    begin
      apb_read(STATUS, d);
      st = status_t'(d[3:0]);
      if (st.busy && (st.rx_valid || st.parity_err || st.resp_timeout))
        fail_msg("STATUS showed result flags before busy cleared");
    end
    while (st.busy);
  endtask

  ////////////////////
  // UART line model
  initial
  begin
    logic [7:0] data;
    logic       par;
    forever
    begin
      @(negedge clk);
      if (rst_n && tx === 1'b0)
      begin
        start_q.push_back(cyc);
        repeat (BIT / 2) @(negedge clk);    // Middle of start bit
        if (tx !== 1'b0)
          fail_msg("tx start bit did not last to its middle");
        for (int b = 0; b < 8; b++)
        begin
          repeat (BIT) @(negedge clk);
          data[b] = tx;                     // LSB first
        end
        repeat (BIT) @(negedge clk);
        par = tx;
        if (par !== ~^data)
          fail_msg("tx frame carries a wrong parity bit");
        repeat (BIT) @(negedge clk);
        if (tx !== 1'b1)
          fail_msg("tx frame has no stop bit");
        byte_q.push_back(data);
      end
    end
  end

  task automatic send_frame(input logic [7:0] data, input int corrupt);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ (corrupt != 0), data, 1'b0};
    for (int b = 0; b < 11; b++)
    begin
      rx = bits[b];
      idle(BIT);
    end
    rx = 1'b1;
  endtask

  task automatic wait_frames(input int n);
    while (byte_q.size() < n)
      idle(1);
  endtask

  ////////////////////
  // One test line
  task automatic run_test(input int i);
    cmd_word_t   exp_cmd;
    cmd_word_t   got_cmd;
    status_t     st;
    logic        err;
    int          acc;
    logic [31:0] d;
    idle(int'($urandom % 5) + 2);
    byte_q.delete();
    start_q.delete();
    exp_cmd = cmd_word_t'(t_cmd[i]);
    apb_write(CMD, {16'h0, t_cmd[i]}, err);
    acc = last_acc;
    check_bit(t_name[i], "pslverr", 1'b0, err);
    if (t_rej[i] != 0)
    begin
      idle(40);                             // Lands inside the hi frame
      apb_write(CMD, {16'h0, ~t_cmd[i]}, err);
      check_bit(t_name[i], "pslverr while busy", 1'b1, err);
    end
    wait_frames(2);
    got_cmd.bytes.hi = byte_q[0];
    got_cmd.bytes.lo = byte_q[1];
    check_cmd(t_name[i], exp_cmd, got_cmd);
    check_cycles(t_name[i], "tx start delay", 2, start_q[0] - acc);
    check_cycles(t_name[i], "frame spacing", 11 * BIT + GAP, start_q[1] - start_q[0]);
    if (t_hasresp[i] != 0)
    begin
      idle(2 * BIT);
      send_frame(t_resp[i], t_cor[i]);
    end
    wait_idle(st);
    check_status(t_name[i], status_t'(t_stat[i]), st);
    if (t_stat[i][2])
    begin
      apb_read(RDATA, d);
      check_byte(t_name[i], t_rdata[i], d[7:0]);
      apb_read(STATUS, d);
      check_status(t_name[i], status_t'(t_stat[i] & 4'b1001), status_t'(d[3:0]));
    end
    idle(GAP + 2 * BIT);
    check_cycles(t_name[i], "frames on tx", 2, start_q.size());
  endtask

  initial
  begin
    int          fd;
    int          n;
    string       line;
    string       nm;
    logic [15:0] c;
    int          rej;
    int          hr;
    int          cor;
    logic [7:0]  rb;
    logic [7:0]  rd;
    logic [3:0]  es;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'h0;
    rx      = 1'b1;
    void'($urandom(32'hbffd));
    fd = $fopen("tb/uart_bridge_stimulus.txt", "r");
    if (fd == 0)
      fail_msg("Cannot open the stimulus file");
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%s %h %d %d %h %d %h %h", nm, c, rej, hr, rb, cor, es, rd);
        if (n != 8)
          fail_msg("Malformed line in the stimulus file");
        t_name.push_back(nm);
        t_cmd.push_back(c);
        t_rej.push_back(rej);
        t_hasresp.push_back(hr);
        t_resp.push_back(rb);
        t_cor.push_back(cor);
        t_stat.push_back(es);
        t_rdata.push_back(rd);
      end
    end
    $fclose(fd);
    cyc_limit = t_name.size() * (2 * 11 * BIT + GAP + `UART_RESP_CYCLES + 64);
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    for (int i = 0; i < t_name.size(); i++)
      run_test(i);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: tb/uart_bridge_stimulus.txt
# name cmd(hex) reject(0/1) has_resp(0/1) resp(hex) corrupt(0/1) exp_status(hex) exp_rdata(hex)
# exp_status bits from msb: busy rx_valid parity_err resp_timeout
write_basic      9a3c 0 0 00 0 0 00
write_ones       ffff 0 0 00 0 0 00
write_zero_data  8000 0 0 00 0 0 00
read_ok          1234 0 1 a5 0 4 a5
read_ok_zero     7f00 0 1 00 0 4 00
read_parity      2211 0 1 5c 1 6 5c
read_timeout     0342 0 0 00 0 1 00
write_busy       c3e1 1 0 00 0 0 00
read_after_to    4501 0 1 ff 0 4 ff
read_parity_ones 6e77 0 1 ff 1 6 ff

// File: uart_bridge.f
+incdir+design
design/uart_frame_pkg.sv
design/uart_bus_pkg.sv
design/uart_apb_regs.sv
design/uart_seq_fsm.sv
design/uart_baud_timer.sv
design/uart_tx_shifter.sv
design/uart_rx_sampler.sv
design/uart_bridge.sv
tb/tb_uart_bridge.sv
